// File: logic/mat_mul_defs.svh
`ifndef MAT_MUL_DEFS_SVH
`define MAT_MUL_DEFS_SVH

// Matrix dimension for rows and columns alike
`define MAT_SIZE 4

// Signed integer element
`define ELEM_WIDTH 16

// Operand and result memories
`define AWIDTH 7
`define MEM_SIZE 128

`endif

// File: logic/mat_mul_pkg.sv
`include "mat_mul_defs.svh"

package mat_mul_pkg;

  // One matrix element with wrapping arithmetic
  typedef logic signed [`ELEM_WIDTH-1:0] elem_t;

  // One memory word holds a full matrix row or column
  // Host port moves the flat bits and the array indexes elements
  typedef union packed {
    logic [`MAT_SIZE*`ELEM_WIDTH-1:0] flat;
    elem_t [`MAT_SIZE-1:0]            elem;
  } mat_word_u;

  // Address into any of the three memories
  typedef logic [`AWIDTH-1:0] mat_addr_t;

endpackage

// File: logic/processing_element.sv
`timescale 1ns/10ps

module processing_element (
  input  logic               clk_mem,
  input  logic               reset,
  input  mat_mul_pkg::elem_t a_in,
  input  mat_mul_pkg::elem_t b_in,
  input  logic               valid_in,
  input  logic               first_in,
  output mat_mul_pkg::elem_t a_out,
  output mat_mul_pkg::elem_t b_out,
  output logic               valid_out,
  output logic               first_out,
  output mat_mul_pkg::elem_t acc
);

  import mat_mul_pkg::*;

  // Only the low bits of the product are kept
  elem_t prod;

  assign prod = a_in * b_in;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      valid_out <= 1'b0;
      first_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
      first_out <= first_in;
    end
  end

  // First product of a run replaces the old sum
  always_ff @(posedge clk_mem) begin
    a_out <= a_in;
    b_out <= b_in;
    if (valid_in) begin
      acc <= first_in ? prod : acc + prod;
    end
  end

endmodule

// File: logic/operand_loader.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module operand_loader (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  logic                   enable_writing_to_mem,
  input  mat_mul_pkg::mat_word_u data_pi,
  input  mat_mul_pkg::mat_addr_t addr_pi,
  input  logic                   we_a,
  input  logic                   we_b,
  input  mat_mul_pkg::mat_addr_t rd_addr,
  input  logic                   rd_valid,
  input  logic                   rd_first,
  output mat_mul_pkg::mat_word_u a_word,
  output mat_mul_pkg::mat_word_u b_word,
  output logic                   op_valid,
  output logic                   op_first
);

  import mat_mul_pkg::*;

  // Host write fields, one edge ahead of the memory write
  logic      wr_en_q;
  logic      we_a_q;
  logic      we_b_q;
  mat_addr_t addr_q;
  mat_word_u data_q;

  mat_addr_t mem_addr;
  mat_word_u mem_a [`MEM_SIZE];
  mat_word_u mem_b [`MEM_SIZE];
  mat_word_u a_rd;
  mat_word_u b_rd;
  logic      valid_d1;
  logic      first_d1;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      wr_en_q <= 1'b0;
      we_a_q  <= 1'b0;
      we_b_q  <= 1'b0;
    end else begin
      wr_en_q <= enable_writing_to_mem;
      we_a_q  <= we_a;
      we_b_q  <= we_b;
    end
  end

  always_ff @(posedge clk_mem) begin
    addr_q      <= addr_pi;
    data_q.flat <= data_pi.flat;
  end

  // Host owns the port while a write is pending
  assign mem_addr = wr_en_q ? addr_q : rd_addr;

  ////////////////////
  // Operand memories
  ////////////////////

  // Read data is registered once more before it leaves
  always_ff @(posedge clk_mem) begin
    if (wr_en_q && we_a_q) begin
      mem_a[mem_addr] <= data_q;
    end
    if (wr_en_q && we_b_q) begin
      mem_b[mem_addr] <= data_q;
    end
    a_rd   <= mem_a[mem_addr];
    b_rd   <= mem_b[mem_addr];
    a_word <= a_rd;
    b_word <= b_rd;
  end

  // Valid and first follow the two read stages
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      valid_d1 <= 1'b0;
      first_d1 <= 1'b0;
      op_valid <= 1'b0;
      op_first <= 1'b0;
    end else begin
      valid_d1 <= rd_valid;
      first_d1 <= rd_first;
      op_valid <= valid_d1;
      op_first <= first_d1;
    end
  end

endmodule

// File: logic/mac_sequencer.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module mac_sequencer (
  input  logic                         clk_mem,
  input  logic                         reset,
  input  logic                         start_mat_mul,
  output mat_mul_pkg::mat_addr_t       rd_addr,
  output logic                         rd_valid,
  output logic                         rd_first,
  output logic [$clog2(`MAT_SIZE)-1:0] row_sel,
  output logic                         c_wr_en,
  output mat_mul_pkg::mat_addr_t       c_wr_addr,
  output logic                         done_mat_mul
);

  import mat_mul_pkg::*;

  // Cycles after the feed until the far corner holds its sum
  // Covers the two read stages, lane skew, grid hops and the last accumulate
  localparam int DRAIN_LEN = 2 * `MAT_SIZE;
  localparam int CNT_W     = $clog2(DRAIN_LEN);

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_FEED     = 3'd1;
  localparam logic [2:0] S_DRAIN    = 3'd2;
  localparam logic [2:0] S_WRITE    = 3'd3;
  localparam logic [2:0] S_DONE     = 3'd4;
  localparam logic [2:0] S_WAIT_LOW = 3'd5;

  logic [2:0]       state;
  logic [CNT_W-1:0] cnt;
  logic             counting;
  logic             cnt_last;

  assign counting = (state == S_FEED) || (state == S_DRAIN) || (state == S_WRITE);
  assign cnt_last = (state == S_DRAIN) ? (cnt == CNT_W'(DRAIN_LEN - 1))
                                       : (cnt == CNT_W'(`MAT_SIZE - 1));

  // One counter serves feed, drain and write
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      cnt <= '0;
    end else if (!counting || cnt_last) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (start_mat_mul) begin
            state <= S_FEED;
          end
        end
        S_FEED: begin
          if (cnt_last) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          if (cnt_last) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (cnt_last) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          state <= S_WAIT_LOW;
        end
        default: begin
          // Start is a level, so a new run needs it to drop first
          if (!start_mat_mul) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  assign rd_valid     = (state == S_FEED);
  assign rd_first     = (state == S_FEED) && (cnt == '0);
  assign rd_addr      = mat_addr_t'(cnt);
  assign c_wr_en      = (state == S_WRITE);
  assign c_wr_addr    = mat_addr_t'(cnt);
  assign row_sel      = cnt[$clog2(`MAT_SIZE)-1:0];
  assign done_mat_mul = (state == S_DONE);

endmodule

// File: logic/systolic_array.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module systolic_array (
  input  logic                         clk_mem,
  input  logic                         reset,
  input  mat_mul_pkg::mat_word_u       a_word,
  input  mat_mul_pkg::mat_word_u       b_word,
  input  logic                         op_valid,
  input  logic                         op_first,
  input  logic [$clog2(`MAT_SIZE)-1:0] row_sel,
  output mat_mul_pkg::mat_word_u       c_row
);

  import mat_mul_pkg::*;

  // Word delayed by d cycles sits at index d
  mat_word_u            a_dly [1:`MAT_SIZE-1];
  mat_word_u            b_dly [1:`MAT_SIZE-1];
  logic [`MAT_SIZE-1:1] v_dly;
  logic [`MAT_SIZE-1:1] f_dly;

  // Skewed lanes entering the west and north edges
  elem_t                lane_a [`MAT_SIZE];
  elem_t                lane_b [`MAT_SIZE];
  logic [`MAT_SIZE-1:0] lane_v;
  logic [`MAT_SIZE-1:0] lane_f;

  // Links between neighbouring cells
  elem_t                a_h      [`MAT_SIZE][`MAT_SIZE];
  elem_t                b_v      [`MAT_SIZE][`MAT_SIZE];
  logic                 v_h      [`MAT_SIZE][`MAT_SIZE];
  logic                 f_h      [`MAT_SIZE][`MAT_SIZE];
  elem_t                acc_grid [`MAT_SIZE][`MAT_SIZE];

  ////////////////////
  // Input skew
  ////////////////////

  always_ff @(posedge clk_mem) begin
    a_dly[1] <= a_word;
    b_dly[1] <= b_word;
    for (int d = 2; d < `MAT_SIZE; d++) begin
      a_dly[d] <= a_dly[d-1];
      b_dly[d] <= b_dly[d-1];
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      v_dly <= '0;
      f_dly <= '0;
    end else begin
      v_dly <= {v_dly[`MAT_SIZE-2:1], op_valid};
      f_dly <= {f_dly[`MAT_SIZE-2:1], op_first};
    end
  end

  // Lane n takes element n of the word delayed by n
  always_comb begin
    lane_a[0] = a_word.elem[0];
    lane_b[0] = b_word.elem[0];
    lane_v[0] = op_valid;
    lane_f[0] = op_first;
    for (int n = 1; n < `MAT_SIZE; n++) begin
      lane_a[n] = a_dly[n].elem[n];
      lane_b[n] = b_dly[n].elem[n];
      lane_v[n] = v_dly[n];
      lane_f[n] = f_dly[n];
    end
  end

  ////////////////////
  // Cell grid
  ////////////////////

  // Valid and first ride east together with A
  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MAT_SIZE; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;
      logic  v_in;
      logic  f_in;

      if (j == 0) begin : g_west
        assign a_in = lane_a[i];
        assign v_in = lane_v[i];
        assign f_in = lane_f[i];
      end else begin : g_inner_a
        assign a_in = a_h[i][j-1];
        assign v_in = v_h[i][j-1];
        assign f_in = f_h[i][j-1];
      end

      if (i == 0) begin : g_north
        assign b_in = lane_b[j];
      end else begin : g_inner_b
        assign b_in = b_v[i-1][j];
      end

      processing_element u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .a_in      (a_in),
        .b_in      (b_in),
        .valid_in  (v_in),
        .first_in  (f_in),
        .a_out     (a_h[i][j]),
        .b_out     (b_v[i][j]),
        .valid_out (v_h[i][j]),
        .first_out (f_h[i][j]),
        .acc       (acc_grid[i][j])
      );
    end
  end

  // One row of sums toward the result store
  always_comb begin
    for (int m = 0; m < `MAT_SIZE; m++) begin
      c_row.elem[m] = acc_grid[row_sel][m];
    end
  end

endmodule

// File: logic/result_store.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module result_store (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  mat_mul_pkg::mat_word_u c_row,
  input  logic                   c_wr_en,
  input  mat_mul_pkg::mat_addr_t c_wr_addr,
  input  logic                   enable_reading_from_mem,
  input  mat_mul_pkg::mat_addr_t addr_pi,
  output mat_mul_pkg::mat_word_u data_from_out_mat
);

  import mat_mul_pkg::*;

  mat_word_u mem_c [`MEM_SIZE];
  mat_addr_t rd_addr_q;
  mat_word_u rd_data;
  logic      rd_en_q;
  logic      rd_en_d2;

  // Read enable walks alongside the address and data stages
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_en_q  <= 1'b0;
      rd_en_d2 <= 1'b0;
    end else begin
      rd_en_q  <= enable_reading_from_mem;
      rd_en_d2 <= rd_en_q;
    end
  end

  ////////////////////
  // C memory
  ////////////////////

  // Row writes come from the sequencer, reads from the host
  always_ff @(posedge clk_mem) begin
    rd_addr_q <= addr_pi;
    if (c_wr_en) begin
      mem_c[c_wr_addr] <= c_row;
    end
    rd_data <= mem_c[rd_addr_q];
  end

  // Output stays zero outside a host read
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      data_from_out_mat.flat <= '0;
    end else begin
      data_from_out_mat.flat <= rd_en_d2 ? rd_data.flat : '0;
    end
  end

endmodule

// File: logic/matrix_multiplication.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module matrix_multiplication (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  logic                   enable_writing_to_mem,
  input  logic                   enable_reading_from_mem,
  input  mat_mul_pkg::mat_word_u data_pi,
  input  mat_mul_pkg::mat_addr_t addr_pi,
  input  logic                   we_a,
  input  logic                   we_b,
  input  logic                   start_mat_mul,
  output mat_mul_pkg::mat_word_u data_from_out_mat,
  output logic                   done_mat_mul
);

  import mat_mul_pkg::*;

  // Operand reads
  mat_addr_t rd_addr;
  logic      rd_valid;
  logic      rd_first;
  mat_word_u a_word;
  mat_word_u b_word;
  logic      op_valid;
  logic      op_first;

  // Result rows
  logic [$clog2(`MAT_SIZE)-1:0] row_sel;
  logic                         c_wr_en;
  mat_addr_t                    c_wr_addr;
  mat_word_u                    c_row;

  operand_loader u_loader (
    .clk_mem               (clk_mem),
    .reset                 (reset),
    .enable_writing_to_mem (enable_writing_to_mem),
    .data_pi               (data_pi),
    .addr_pi               (addr_pi),
    .we_a                  (we_a),
    .we_b                  (we_b),
    .rd_addr               (rd_addr),
    .rd_valid              (rd_valid),
    .rd_first              (rd_first),
    .a_word                (a_word),
    .b_word                (b_word),
    .op_valid              (op_valid),
    .op_first              (op_first)
  );

  mac_sequencer u_sequencer (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .rd_addr       (rd_addr),
    .rd_valid      (rd_valid),
    .rd_first      (rd_first),
    .row_sel       (row_sel),
    .c_wr_en       (c_wr_en),
    .c_wr_addr     (c_wr_addr),
    .done_mat_mul  (done_mat_mul)
  );

  systolic_array u_array (
    .clk_mem  (clk_mem),
    .reset    (reset),
    .a_word   (a_word),
    .b_word   (b_word),
    .op_valid (op_valid),
    .op_first (op_first),
    .row_sel  (row_sel),
    .c_row    (c_row)
  );

  result_store u_store (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .c_row                   (c_row),
    .c_wr_en                 (c_wr_en),
    .c_wr_addr               (c_wr_addr),
    .enable_reading_from_mem (enable_reading_from_mem),
    .addr_pi                 (addr_pi),
    .data_from_out_mat       (data_from_out_mat)
  );

endmodule

// File: test/mat_mul_chk.sv
`timescale 1ns/10ps

module mat_mul_chk (
  input logic clk_mem,
  input logic reset,
  input logic start_mat_mul,
  input logic done_mat_mul
);

  // Done lasts exactly one cycle
  done_single_pulse: assert property (
    @(posedge clk_mem) disable iff (reset) done_mat_mul |=> !done_mat_mul
  ) else $error("done_mat_mul stayed high for more than one cycle");

  // A run only finishes while start is still held
  done_needs_start: assert property (
    @(posedge clk_mem) disable iff (reset) $rose(done_mat_mul) |-> start_mat_mul
  ) else $error("done_mat_mul rose while start_mat_mul was low");

  // Sequencer comes out of reset idle
  done_low_after_reset: assert property (
    @(posedge clk_mem) reset |=> !done_mat_mul
  ) else $error("done_mat_mul was high in the cycle after reset");

endmodule

bind matrix_multiplication mat_mul_chk u_chk (
  .clk_mem       (clk_mem),
  .reset         (reset),
  .start_mat_mul (start_mat_mul),
  .done_mat_mul  (done_mat_mul)
);

// File: test/tb_matrix_multiplication.sv
`timescale 1ns/10ps
`include "mat_mul_defs.svh"

module tb_matrix_multiplication;

  import mat_mul_pkg::*;

  localparam int          WORD_W       = `MAT_SIZE * `ELEM_WIDTH;
  localparam int          DONE_TIMEOUT = 200;
  localparam logic [31:0] LFSR_SEED    = 32'h8733;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic      clk_mem = 1'b0;
  logic      reset;
  logic      enable_writing_to_mem;
  logic      enable_reading_from_mem;
  mat_word_u data_pi;
  mat_addr_t addr_pi;
  logic      we_a;
  logic      we_b;
  logic      start_mat_mul;
  mat_word_u data_from_out_mat;
  logic      done_mat_mul;

  // Host copies of the operands and the expected C rows
  elem_t       mat_a [`MAT_SIZE][`MAT_SIZE];
  elem_t       mat_b [`MAT_SIZE][`MAT_SIZE];
  mat_word_u   exp_c [`MAT_SIZE];
  logic [31:0] lfsr_state = LFSR_SEED;

  // Host reads in flight, as the DUT sampled them
  logic [2:0] rd_pipe_v = '0;
  mat_addr_t  rd_pipe_a [3];
  logic       checks_on = 1'b0;

  matrix_multiplication UUT (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  always #20 clk_mem = ~clk_mem;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = {1'b0, s[31:1]};
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  // One LFSR step per bit of the element
  function automatic elem_t random_elem();
    elem_t e;
    e = '0;
    for (int b = 0; b < `ELEM_WIDTH; b++) begin
      e = {e[`ELEM_WIDTH-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return e;
  endfunction

  // Row i of A times column j of B, wrapped to the element width
  function automatic elem_t ref_elem(input int i, input int j);
    elem_t sum;
    elem_t prod;
    sum = '0;
    for (int k = 0; k < `MAT_SIZE; k++) begin
      prod = mat_a[i][k] * mat_b[k][j];
      sum  = sum + prod;
    end
    return sum;
  endfunction

  task automatic fail_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int j = 0; j < `MAT_SIZE; j++) begin
        mat_a[i][j] = random_elem();
        mat_b[i][j] = random_elem();
      end
    end
  endtask

  task automatic expect_from_ref();
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int j = 0; j < `MAT_SIZE; j++) begin
        exp_c[i].elem[j] = ref_elem(i, j);
      end
    end
  endtask

  task automatic write_word(input logic to_a, input int addr, input mat_word_u w);
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b1;
    we_a    = to_a;
    we_b    = !to_a;
    addr_pi = mat_addr_t'(addr);
    data_pi = w;
  endtask

  // A goes in by columns, B by rows
  task automatic load_matrices();
    mat_word_u w;
    for (int k = 0; k < `MAT_SIZE; k++) begin
      for (int n = 0; n < `MAT_SIZE; n++) begin
        w.elem[n] = mat_a[n][k];
      end
      write_word(1'b1, k, w);
    end
    for (int k = 0; k < `MAT_SIZE; k++) begin
      for (int n = 0; n < `MAT_SIZE; n++) begin
        w.elem[n] = mat_b[k][n];
      end
      write_word(1'b0, k, w);
    end
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
  endtask

  task automatic run_matmul(input int hold_cycles);
    int waited;
    @(negedge clk_mem);
    start_mat_mul = 1'b1;
    waited = 0;
    do begin
      @(negedge clk_mem);
      waited++;
    end while (!done_mat_mul && waited < DONE_TIMEOUT);
    if (!done_mat_mul) begin
      $display("Timeout at %0d ns: done_mat_mul did not rise within %0d cycles",
               $time, DONE_TIMEOUT);
      fail_run();
    end
    // Start still high, so no second run may begin
    for (int c = 0; c < hold_cycles; c++) begin
      @(negedge clk_mem);
      check_value("done_mat_mul while start is held", WORD_W'(done_mat_mul), '0);
    end
    start_mat_mul = 1'b0;
  endtask

  // One address per cycle
  task automatic read_rows(input logic descending);
    int row;
    for (int n = 0; n < `MAT_SIZE; n++) begin
      row = descending ? `MAT_SIZE - 1 - n : n;
      @(negedge clk_mem);
      enable_reading_from_mem = 1'b1;
      addr_pi = mat_addr_t'(row);
    end
    @(negedge clk_mem);
    enable_reading_from_mem = 1'b0;
    // Last word leaves three edges after its address
    repeat (4) @(negedge clk_mem);
  endtask

  ////////////////////
  // Read-back compare
  ////////////////////

  always @(posedge clk_mem) begin
    checks_on <= !reset;
    if (reset) begin
      rd_pipe_v <= '0;
    end else begin
      rd_pipe_v <= {rd_pipe_v[1:0], enable_reading_from_mem};
    end
    rd_pipe_a[0] <= addr_pi;
    rd_pipe_a[1] <= rd_pipe_a[0];
    rd_pipe_a[2] <= rd_pipe_a[1];
  end

  // Each sampled address must show its row exactly three edges on
  always @(negedge clk_mem) begin
    if (checks_on) begin
      if (rd_pipe_v[2]) begin
        check_value($sformatf("C row %0d", rd_pipe_a[2]), data_from_out_mat.flat,
                    exp_c[rd_pipe_a[2][1:0]].flat);
      end else begin
        check_value("output outside a read", data_from_out_mat.flat, '0);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    reset                   = 1'b1;
    enable_writing_to_mem   = 1'b0;
    enable_reading_from_mem = 1'b0;
    data_pi                 = '0;
    addr_pi                 = '0;
    we_a                    = 1'b0;
    we_b                    = 1'b0;
    start_mat_mul           = 1'b0;
    repeat (3) @(negedge clk_mem);
    reset = 1'b0;

    @(negedge clk_mem);
    check_value("done_mat_mul after reset", WORD_W'(done_mat_mul), '0);
    check_value("data_from_out_mat after reset", data_from_out_mat.flat, '0);

    // Identity A, so C is B
    fill_random();
    for (int i = 0; i < `MAT_SIZE; i++) begin
      for (int j = 0; j < `MAT_SIZE; j++) begin
        mat_a[i][j]      = (i == j) ? elem_t'(1) : elem_t'(0);
        exp_c[i].elem[j] = mat_b[i][j];
      end
    end
    load_matrices();
    run_matmul(1);
    read_rows(1'b0);

    fill_random();
    expect_from_ref();
    load_matrices();
    run_matmul(1);
    read_rows(1'b0);

    // Back to back run without reset, rows read in reverse
    fill_random();
    expect_from_ref();
    load_matrices();
    run_matmul(1);
    read_rows(1'b1);

    // Long start level, then a fresh start
    fill_random();
    expect_from_ref();
    load_matrices();
    run_matmul(30);
    fill_random();
    expect_from_ref();
    load_matrices();
    run_matmul(1);
    read_rows(1'b0);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: systolic_matmul.f
+incdir+logic
logic/mat_mul_pkg.sv
logic/processing_element.sv
logic/operand_loader.sv
logic/mac_sequencer.sv
logic/systolic_array.sv
logic/result_store.sv
logic/matrix_multiplication.sv
test/mat_mul_chk.sv
test/tb_matrix_multiplication.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the simulation model from the file list
verilator --binary --timing --assert \
  -f systolic_matmul.f \
  --top-module tb_matrix_multiplication \
  -o sim_matmul

# Exit status of the model is the test result
./obj_dir/sim_matmul
